// File: hw/fpFormatPkg.sv
package fpFormatPkg;

  // Memory word format selected by a load or a store
  typedef enum logic {
    FmtSingle = 1'b0,
    FmtDouble = 1'b1
  } memFmt_e;

  // IEEE single field layout
  localparam int SglExpWidth  = 8;
  localparam int SglFracWidth = 23;
  localparam int SglBias      = 127;

  // IEEE double field layout
  localparam int DblExpWidth  = 11;
  localparam int DblFracWidth = 52;
  localparam int DblBias      = 1023;

endpackage

// File: hw/fpNativePkg.sv
package fpNativePkg;

  // Layout of a register file entry
  typedef enum logic {
    PrecExt = 1'b0,   // Extended with explicit integer bit
    PrecDbl = 1'b1    // Native double with hidden one
  } nativePrec_e;

  // One 80-bit register word read through the view its tag names
  typedef union packed {
    struct packed {
      logic        sign;
      logic [14:0] exp;
      logic [63:0] sig;   // Bit 63 is the integer bit
    } ext;
    struct packed {
      logic [14:0] pad;
      logic        sign;
      logic [11:0] exp;   // Widened exponent
      logic [51:0] frac;
    } dbl;
  } nativeWord_u;

  localparam int ExtBias    = 16383;
  localparam int NatDblBias = 2047;

  // All-ones exponents mark infinity and NaN
  localparam logic [14:0] ExtExpMax    = 15'h7fff;
  localparam logic [11:0] NatDblExpMax = 12'hfff;

endpackage

// File: hw/fpLeadingOne.sv
`timescale 1ns/1ps

module fpLeadingOne (
  input  logic [51:0] frac,
  output logic [5:0]  pos,
  output logic        found
);

  // Later iterations win, so the highest set bit sets pos
  always_comb begin
    pos   = '0;
    found = 1'b0;
    for (int i = 0; i < 52; i++) begin
      if (frac[i]) begin
        pos   = 6'(51 - i);   // Distance from the top bit
        found = 1'b1;
      end
    end
  end

endmodule

// File: hw/fpLoadConvert.sv
`timescale 1ns/1ps

module fpLoadConvert
  import fpFormatPkg::*;
  import fpNativePkg::*;
(
  input  logic [63:0] ldData,
  input  memFmt_e     ldFmt,
  input  logic        ldToExt,
  output nativeWord_u nativeData,
  output nativePrec_e nativePrec
);

  localparam int DblExpTop = DblExpWidth + DblFracWidth - 1;
  localparam int SglExpTop = SglExpWidth + SglFracWidth - 1;

  logic [DblFracWidth-1:0] sglFrac;
  logic [DblFracWidth-1:0] dblFrac;
  logic [DblFracWidth-1:0] alignedFrac;
  logic [DblFracWidth-1:0] normFrac;
  logic [5:0]              sglPos;
  logic [5:0]              dblPos;
  logic [5:0]              leadPos;
  logic                    sglFound;
  logic                    dblFound;
  logic                    leadFound;
  logic                    sign;
  logic [DblExpWidth-1:0]  biasedExp;
  logic [DblExpWidth-1:0]  bias;
  logic                    expZero;
  logic                    expMax;
  logic                    isZero;
  logic [15:0]             unbExp;

  assign sglFrac = {ldData[SglFracWidth-1:0], {(DblFracWidth - SglFracWidth){1'b0}}};
  assign dblFrac = ldData[DblFracWidth-1:0];

  fpLeadingOne sglLead0 (
    .frac  (sglFrac),
    .pos   (sglPos),
    .found (sglFound)
  );

  fpLeadingOne dblLead0 (
    .frac  (dblFrac),
    .pos   (dblPos),
    .found (dblFound)
  );

  always_comb begin
    if (ldFmt == FmtDouble) begin
      sign        = ldData[DblExpTop+1];
      biasedExp   = ldData[DblExpTop:DblFracWidth];
      bias        = 11'(DblBias);
      alignedFrac = dblFrac;
      leadPos     = dblPos;
      leadFound   = dblFound;
      expMax      = &biasedExp;
    end else begin
      sign        = ldData[SglExpTop+1];
      biasedExp   = 11'(ldData[SglExpTop:SglFracWidth]);
      bias        = 11'(SglBias);
      alignedFrac = sglFrac;
      leadPos     = sglPos;
      leadFound   = sglFound;
      expMax      = &biasedExp[SglExpWidth-1:0];
    end
  end

  assign expZero = (biasedExp == '0);
  assign isZero  = expZero & ~leadFound;

  // Denormal input loses its leading one into the hidden bit
  assign normFrac = expZero ? alignedFrac << (7'(leadPos) + 7'd1) : alignedFrac;
  assign unbExp   = expZero ? 16'd0 - 16'(bias) - 16'(leadPos)
                            : 16'(biasedExp) - 16'(bias);

  assign nativePrec = ldToExt ? PrecExt : PrecDbl;

  always_comb begin
    nativeData = '0;
    if (ldToExt) begin
      nativeData.ext.sign = sign;
      if (expMax) begin
        nativeData.ext.exp = ExtExpMax;
        nativeData.ext.sig = {1'b1, alignedFrac, 11'b0};
      end else if (!isZero) begin
        nativeData.ext.exp = 15'(unbExp + 16'(ExtBias));
        nativeData.ext.sig = {1'b1, normFrac, 11'b0};
      end
    end else begin
      nativeData.dbl.sign = sign;
      if (expMax) begin
        nativeData.dbl.exp  = NatDblExpMax;
        nativeData.dbl.frac = alignedFrac;
      end else if (!isZero) begin
        nativeData.dbl.exp  = 12'(unbExp + 16'(NatDblBias));
        nativeData.dbl.frac = normFrac;
      end
    end
  end

endmodule

// File: hw/fpRegFile.sv
`timescale 1ns/1ps

module fpRegFile
  import fpNativePkg::*;
#(
  parameter int NumRegs = 8
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       wrEn,
  input  logic [$clog2(NumRegs)-1:0] wrAddr,
  input  nativeWord_u                wrData,
  input  nativePrec_e                wrPrec,
  input  logic [$clog2(NumRegs)-1:0] rdAddr,
  output nativeWord_u                rdData,
  output nativePrec_e                rdPrec
);

  nativeWord_u entries [NumRegs];
  nativePrec_e tags    [NumRegs];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NumRegs; i++) begin
        entries[i] <= '0;        // Extended positive zero
        tags[i]    <= PrecExt;
      end
    end else if (wrEn) begin
      entries[wrAddr] <= wrData;
      tags[wrAddr]    <= wrPrec;
    end
  end

  // Same-cycle write is not visible until the next cycle
  assign rdData = entries[rdAddr];
  assign rdPrec = tags[rdAddr];

endmodule

// File: hw/fpStoreConvert.sv
`timescale 1ns/1ps

module fpStoreConvert
  import fpFormatPkg::*;
  import fpNativePkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        stStrobe,
  input  memFmt_e     stFmt,
  input  nativeWord_u rdData,
  input  nativePrec_e rdPrec,
  output logic [63:0] stData,
  output logic        stValid
);

  logic                    sign;
  logic                    special;
  logic                    zeroIn;
  logic                    isNaN;
  logic signed [15:0]      unbExp;
  logic [63:0]             sig;
  logic signed [15:0]      tgtBias;
  logic signed [15:0]      tgtFracW;
  logic signed [15:0]      minNorm;
  logic signed [15:0]      minDen;
  logic [6:0]              denShift;
  logic [63:0]             shiftedSig;
  logic [DblExpWidth-1:0]  outExp;
  logic [DblFracWidth-1:0] outFrac;
  logic [63:0]             nextData;

  // Common sign, exponent and integer-bit significand
  always_comb begin
    if (rdPrec == PrecExt) begin
      sign    = rdData.ext.sign;
      special = (rdData.ext.exp == ExtExpMax);
      zeroIn  = (rdData.ext.exp == '0);
      unbExp  = 16'(rdData.ext.exp) - 16'(ExtBias);
      sig     = rdData.ext.sig;
    end else begin
      sign    = rdData.dbl.sign;
      special = (rdData.dbl.exp == NatDblExpMax);
      zeroIn  = (rdData.dbl.exp == '0);
      unbExp  = 16'(rdData.dbl.exp) - 16'(NatDblBias);
      sig     = {1'b1, rdData.dbl.frac, 11'b0};
    end
  end

  assign tgtBias  = (stFmt == FmtDouble) ? 16'(DblBias) : 16'(SglBias);
  assign tgtFracW = (stFmt == FmtDouble) ? 16'(DblFracWidth) : 16'(SglFracWidth);
  assign minNorm  = 16'sd1 - tgtBias;
  assign minDen   = minNorm - tgtFracW;   // Exponent of the smallest denormal

  assign denShift   = 7'(minNorm - unbExp);
  assign shiftedSig = sig >> denShift;
  assign isNaN      = special && (sig[62:0] != '0);

  // Fraction kept left-aligned in 52 bits for both targets
  always_comb begin
    outExp  = '0;
    outFrac = '0;
    if (special) begin
      outExp      = '1;
      outFrac     = sig[62:11];
      outFrac[51] = outFrac[51] | isNaN;   // Keep NaN a NaN after truncation
    end else if (unbExp > tgtBias) begin
      outExp = '1;                         // Infinity
    end else if (zeroIn || unbExp < minDen) begin
      outFrac = '0;                        // Signed zero
    end else if (unbExp < minNorm) begin
      outFrac = shiftedSig[62:11];
    end else begin
      outExp  = 11'(unbExp + tgtBias);
      outFrac = sig[62:11];
    end
  end

  always_comb begin
    if (stFmt == FmtDouble) begin
      nextData = {sign, outExp, outFrac};
    end else begin
      nextData = {32'b0, sign, outExp[SglExpWidth-1:0],
                  outFrac[DblFracWidth-1 -: SglFracWidth]};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stValid <= 1'b0;
      stData  <= '0;
    end else begin
      stValid <= stStrobe;
      if (stStrobe) begin
        stData <= nextData;
      end
    end
  end

endmodule

// File: hw/fpLoadStore.sv
`timescale 1ns/1ps

module fpLoadStore
  import fpFormatPkg::*;
  import fpNativePkg::*;
#(
  parameter int NumRegs = 8
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       ldStrobe,
  input  logic [$clog2(NumRegs)-1:0] ldAddr,
  input  memFmt_e                    ldFmt,
  input  logic                       ldToExt,
  input  logic [63:0]                ldData,
  input  logic                       stStrobe,
  input  logic [$clog2(NumRegs)-1:0] stAddr,
  input  memFmt_e                    stFmt,
  output logic [63:0]                stData,
  output logic                       stValid
);

  nativeWord_u nativeData;
  nativePrec_e nativePrec;
  nativeWord_u rdData;
  nativePrec_e rdPrec;

  fpLoadConvert load0 (
    .ldData     (ldData),
    .ldFmt      (ldFmt),
    .ldToExt    (ldToExt),
    .nativeData (nativeData),
    .nativePrec (nativePrec)
  );

  fpRegFile #(
    .NumRegs (NumRegs)
  ) regs0 (
    .clk    (clk),
    .reset  (reset),
    .wrEn   (ldStrobe),
    .wrAddr (ldAddr),
    .wrData (nativeData),
    .wrPrec (nativePrec),
    .rdAddr (stAddr),
    .rdData (rdData),
    .rdPrec (rdPrec)
  );

  fpStoreConvert store0 (
    .clk      (clk),
    .reset    (reset),
    .stStrobe (stStrobe),
    .stFmt    (stFmt),
    .rdData   (rdData),
    .rdPrec   (rdPrec),
    .stData   (stData),
    .stValid  (stValid)
  );

endmodule

// File: tests/fpLoadStore_checker.sv
`timescale 1ns/1ps

module fpLoadStore_checker (
  input logic        clk,
  input logic        reset,
  input logic        stStrobe,
  input logic        stValid,
  input logic [63:0] stData
);

  int failCount = 0;   // Failed assertions so far

  assert property (@(posedge clk) reset |=> !stValid)
    else begin
      failCount++;
      $error("stValid high in the cycle after reset");
    end

  // Result register has exactly one cycle of latency
  assert property (@(posedge clk) disable iff (reset) stStrobe |=> stValid)
    else begin
      failCount++;
      $error("stValid missing one cycle after stStrobe");
    end
  assert property (@(posedge clk) disable iff (reset) !stStrobe |=> !stValid)
    else begin
      failCount++;
      $error("stValid high without a stStrobe in the cycle before");
    end

  assert property (@(posedge clk) disable iff (reset) stValid |-> !$isunknown(stData))
    else begin
      failCount++;
      $error("stData has unknown bits while stValid is high");
    end

endmodule

bind fpLoadStore fpLoadStore_checker check0 (
  .clk      (clk),
  .reset    (reset),
  .stStrobe (stStrobe),
  .stValid  (stValid),
  .stData   (stData)
);

// File: tests/fpLoadStore_tb.sv
`timescale 1ns/1ps

module fpLoadStore_tb
  import fpFormatPkg::*;
();

  logic clk, reset, ldStrobe, ldToExt, stStrobe, stValid;
  logic [2:0] ldAddr, stAddr;
  memFmt_e ldFmt, stFmt;
  logic [63:0] ldData, stData;
  logic [63:0] expQ [$];
  int issueQ [$];
  logic [63:0] shadowWord [8];
  bit shadowDbl [8];
  logic [63:0] sglVals [12];
  logic [63:0] dblVals [16];
  logic [63:0] rndWord;
  int order [8];
  int cycCount = 0;
  int opsIssued = 0;
  int valueErrors = 0;
  int protocolErrors = 0;

  fpLoadStore #(.NumRegs(8)) dut0 (
    .clk(clk), .reset(reset), .ldStrobe(ldStrobe), .ldAddr(ldAddr), .ldFmt(ldFmt),
    .ldToExt(ldToExt), .ldData(ldData), .stStrobe(stStrobe), .stAddr(stAddr),
    .stFmt(stFmt), .stData(stData), .stValid(stValid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Expected memory word for a store derived from the loaded IEEE fields
  function automatic logic [63:0] refStore(input logic [63:0] word, input bit srcDbl,
                                           input bit dstDbl);
    logic sign;
    logic [51:0] f, of;
    logic [10:0] oe;
    logic [63:0] sig;
    int rawExp, maxExp, bias, e, tBias, tFrac, minNorm;
    sign   = srcDbl ? word[63] : word[31];
    rawExp = srcDbl ? int'(word[62:52]) : int'(word[30:23]);
    f      = srcDbl ? word[51:0] : {word[22:0], 29'b0};
    bias   = srcDbl ? 1023 : 127;
    maxExp = srcDbl ? 2047 : 255;
    e      = rawExp - bias;
    sig    = {1'b1, f, 11'b0};
    if (rawExp == 0 && f != 0) begin
      e   = 1 - bias;
      sig = {1'b0, f, 11'b0};
      while (!sig[63]) begin
        sig = sig << 1;
        e--;
      end
    end
    tBias   = dstDbl ? 1023 : 127;
    tFrac   = dstDbl ? 52 : 23;
    minNorm = 1 - tBias;
    oe = '0;
    of = '0;
    if (rawExp == maxExp) begin
      oe = '1;
      of = sig[62:11];
      if (of != 0) of[51] = 1'b1;  // NaN stays a NaN
    end else if (rawExp == 0 && f == 0) begin
      of = '0;
    end else if (e > tBias) begin
      oe = '1;
    end else if (e >= minNorm - tFrac && e < minNorm) begin
      sig = sig >> (minNorm - e);
      of  = sig[62:11];
    end else if (e >= minNorm) begin
      oe = 11'(e + tBias);
      of = sig[62:11];
    end
    return dstDbl ? {sign, oe, of} : {32'b0, sign, oe[7:0], of[51:29]};
  endfunction

  task automatic driveCycle(input bit doLd, input logic [2:0] la, input bit lf, input bit le,
                            input logic [63:0] ld, input bit doSt, input logic [2:0] sa,
                            input bit sf);
    @(negedge clk);
    ldStrobe = doLd;
    ldAddr   = la;
    ldFmt    = lf ? FmtDouble : FmtSingle;
    ldToExt  = le;
    ldData   = ld;
    stStrobe = doSt;
    stAddr   = sa;
    stFmt    = sf ? FmtDouble : FmtSingle;
    if (doSt) begin  // Store sees the contents before this cycle's load
      expQ.push_back(refStore(shadowWord[sa], shadowDbl[sa], sf));
      issueQ.push_back(cycCount);
      opsIssued++;
    end
    if (doLd) begin
      shadowWord[la] = ld;
      shadowDbl[la]  = lf;
      opsIssued++;
    end
  endtask

  task automatic roundTrip(input logic [63:0] data, input bit fmt, input bit ext,
                           input logic [2:0] r);
    driveCycle(1, r, fmt, ext, data, 0, 0, 0);
    driveCycle(0, 0, 0, 0, 0, 1, r, 0);
    driveCycle(0, 0, 0, 0, 0, 1, r, 1);
  endtask

  always @(posedge clk) begin
    cycCount = cycCount + 1;
    if (cycCount > 2 * opsIssued + 200) begin
      $display("Timeout after %0d cycles with %0d stores outstanding", cycCount, expQ.size());
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  always @(negedge clk) begin
    logic [63:0] expected;
    if (!reset) begin
      if (stValid) begin
        if (expQ.size() == 0) begin
          protocolErrors++;
          $display("stValid went high with no store pending");
        end else begin
          expected = expQ.pop_front();
          void'(issueQ.pop_front());
          if (stData !== expected) begin
            valueErrors++;
            $display("FAILED stData expected %h actual %h", expected, stData);
          end
        end
      end else if (issueQ.size() != 0 && issueQ[0] < cycCount) begin
        protocolErrors++;
        $display("Store issued in cycle %0d gave no stValid", issueQ[0]);
        void'(expQ.pop_front());
        void'(issueQ.pop_front());
      end
    end
  end

  initial begin
    void'($urandom(32'h04bc_8c6e));
    reset    = 1'b1;
    ldStrobe = 1'b0;
    ldAddr   = '0;
    ldFmt    = FmtSingle;
    ldToExt  = 1'b0;
    ldData   = '0;
    stStrobe = 1'b0;
    stAddr   = '0;
    stFmt    = FmtSingle;
    for (int i = 0; i < 8; i++) begin
      shadowWord[i] = '0;
      shadowDbl[i]  = 1'b0;
    end
    sglVals = '{64'h0, 64'h8000_0000, 64'h1, 64'h007f_ffff, 64'h0080_0000, 64'h7f7f_ffff,
                64'h7f80_0000, 64'hff80_0000, 64'h7fc0_0000, 64'h7f80_0001, 64'h3f80_0000,
                64'h8040_0001};
    dblVals = '{64'h0, 64'h8000_0000_0000_0000, 64'h1, 64'h000f_ffff_ffff_ffff,
                64'h0010_0000_0000_0000, 64'h7fef_ffff_ffff_ffff, 64'h7ff0_0000_0000_0000,
                64'hfff0_0000_0000_0000, 64'h7ff0_0000_0000_0001, 64'h47ef_ffff_e000_0000,
                64'h47f0_0000_0000_0000, 64'h3810_0000_0000_0000, 64'h36a0_0000_0000_0000,
                64'h3690_0000_0000_0000, 64'hb7fa_bcde_f123_4567, 64'h3ff1_2345_6789_abcd};
    order = '{5, 2, 7, 0, 3, 6, 1, 4};
    repeat (16) @(negedge clk);
    reset = 1'b0;
    repeat (3) driveCycle(0, 0, 0, 0, 0, 0, 0, 0);
    for (int r = 0; r < 8; r++) driveCycle(0, 0, 0, 0, 0, 1, 3'(r), r[0]);  // Unloaded
    for (int i = 0; i < 12; i++) begin
      roundTrip(sglVals[i], 0, 0, 3'(i));
      roundTrip(sglVals[i], 0, 1, 3'(i + 3));
    end
    for (int i = 0; i < 16; i++) begin
      roundTrip(dblVals[i], 1, 0, 3'(i));
      roundTrip(dblVals[i], 1, 1, 3'(i + 5));
    end
    for (int r = 0; r < 8; r++) driveCycle(1, 3'(r), 1, r[1], dblVals[r + 8], 0, 0, 0);
    for (int i = 0; i < 16; i++) driveCycle(0, 0, 0, 0, 0, 1, 3'(order[i % 8]), i[3]);
    driveCycle(1, 3, 0, 1, sglVals[10], 1, 3, 1);  // Same-cycle store reads old value
    driveCycle(0, 0, 0, 0, 0, 1, 3, 1);
    repeat (300) begin
      if ($urandom % 2) begin
        rndWord = {$urandom, $urandom};
      end else begin
        rndWord = {1'($urandom), 11'(864 + $urandom % 290), 52'({$urandom, $urandom})};
      end
      driveCycle(1, 3'($urandom), 1'($urandom), 1'($urandom), rndWord,
                 1, 3'($urandom), 1'($urandom));
    end
    while (expQ.size() != 0) driveCycle(0, 0, 0, 0, 0, 0, 0, 0);
    driveCycle(0, 0, 0, 0, 0, 0, 0, 0);
    $display("Errors: %0d value, %0d protocol, %0d assertion", valueErrors, protocolErrors,
             dut0.check0.failCount);
    if (valueErrors + protocolErrors + dut0.check0.failCount == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: fpLoadStore.f
hw/fpFormatPkg.sv
hw/fpNativePkg.sv
hw/fpLeadingOne.sv
hw/fpLoadConvert.sv
hw/fpRegFile.sv
hw/fpStoreConvert.sv
hw/fpLoadStore.sv
tests/fpLoadStore_checker.sv
tests/fpLoadStore_tb.sv
